// ==== compile.f ====
hdl/spiPkg.sv
hdl/flashPkg.sv
hdl/spiByteEngine.sv
hdl/byteFifo.sv
hdl/wordReader.sv
hdl/readSequencer.sv
hdl/flashReader.sv
tests/flashModel.sv
tests/readChecker.sv
tests/flashReader_assert.sv
tests/flashReaderTb.sv

// ==== hdl/byteFifo.sv ====
// circular byte buffer with push and pop strobes, empty and full levels
`timescale 1ns/1ps
`default_nettype none

module byteFifo (
	input wire clk,
	input wire rstN,
	input wire push, // never while full
	input wire [spiPkg::BYTE_BITS-1:0] pushData,
	input wire pop, // never while empty
	output logic [spiPkg::BYTE_BITS-1:0] popData, // head entry
	output logic empty,
	output logic full
);
	import spiPkg::*;
	import flashPkg::*;

	logic [BYTE_BITS-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wrPtr; // depth is a power of two, pointers wrap
	logic [FIFO_PTR_BITS-1:0] rdPtr;
	logic [FIFO_PTR_BITS:0] count; // 0 .. FIFO_DEPTH

	assign popData = mem[rdPtr];
	assign empty = (count == '0);
	assign full = (count == (FIFO_PTR_BITS + 1)'(FIFO_DEPTH));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushData; // seen at popData next cycle
	end

endmodule

`default_nettype wire

// ==== hdl/flashPkg.sv ====
// flash opcodes, address and count widths, buffer sizing, sequencer state type
`default_nettype none

package flashPkg;

	localparam int ADDR_BITS = 24; // byte address on the flash
	localparam int WORD_COUNT_BITS = 8; // host request size in 16-bit words
	localparam int FIFO_DEPTH = 8; // byte entries in the read buffer
	localparam int FIFO_PTR_BITS = 3; // log2 of FIFO_DEPTH

	// only plain READ is issued for now
	// fast read, status and erase opcodes would join here
	typedef enum logic [7:0] {
		opRead = 8'h03
	} flashOp_t;

	typedef enum logic [2:0] {
		seqIdle, // csN high, waiting for start
		seqCommand, // opcode byte
		seqAddress, // three address bytes, high first
		seqData, // stream bytes into the buffer
		seqRelease // csN back high, then readDone
	} seqState_t;

endpackage

`default_nettype wire

// ==== hdl/flashReader.sv ====
// flash read path top, sequencer into byte buffer into word reader
`timescale 1ns/1ps
`default_nettype none

module flashReader (
	input wire clk,
	input wire rstN,
	input wire start,
	input wire [flashPkg::ADDR_BITS-1:0] startAddr,
	input wire [flashPkg::WORD_COUNT_BITS-1:0] wordCount,
	input wire next,
	input wire miso,
	output logic sck,
	output logic csN,
	output logic mosi,
	output logic busy,
	output logic readDone,
	output logic [2*spiPkg::BYTE_BITS-1:0] word,
	output logic wordValid
);
	import spiPkg::*;

	logic push;
	logic [BYTE_BITS-1:0] pushData;
	logic full; // back-pressure to the sequencer, stalls sck
	logic pop;
	logic [BYTE_BITS-1:0] popData;
	logic empty;

	readSequencer i_sequencer (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.startAddr(startAddr),
		.wordCount(wordCount),
		.miso(miso),
		.sck(sck),
		.mosi(mosi),
		.csN(csN),
		.busy(busy),
		.readDone(readDone),
		.push(push),
		.pushData(pushData),
		.full(full)
	);

	byteFifo i_fifo (
		.clk(clk),
		.rstN(rstN),
		.push(push),
		.pushData(pushData),
		.pop(pop),
		.popData(popData),
		.empty(empty),
		.full(full)
	);

	wordReader i_reader (
		.clk(clk),
		.rstN(rstN),
		.next(next),
		.popData(popData),
		.empty(empty),
		.pop(pop),
		.word(word),
		.wordValid(wordValid)
	);

endmodule

`default_nettype wire

// ==== hdl/readSequencer.sv ====
// READ command sequencer, issues opcode and address then streams data bytes
`timescale 1ns/1ps
`default_nettype none

module readSequencer (
	input wire clk,
	input wire rstN,
	input wire start, // one-cycle request, ignored while busy
	input wire [flashPkg::ADDR_BITS-1:0] startAddr,
	input wire [flashPkg::WORD_COUNT_BITS-1:0] wordCount,
	input wire miso,
	output logic sck,
	output logic mosi,
	output logic csN,
	output logic busy,
	output logic readDone, // one-cycle pulse after csN has risen
	output logic push,
	output logic [spiPkg::BYTE_BITS-1:0] pushData,
	input wire full
);
	import spiPkg::*;
	import flashPkg::*;

	seqState_t state;
	logic csSetup; // one cycle of csN low before the first sck
	logic byteActive; // engine holds a byte between load and byteDone
	logic load;
	logic byteDone;
	logic [1:0] stepCnt; // address byte index, then release wait
	logic [WORD_COUNT_BITS:0] dataLeft; // data bytes not yet started
	logic [ADDR_BITS-1:0] addrReg;
	logic [BYTE_BITS-1:0] txByte;
	logic [BYTE_BITS-1:0] rxByte;

	spiByteEngine i_engine (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.txByte(txByte),
		.miso(miso),
		.byteDone(byteDone),
		.rxByte(rxByte),
		.sck(sck),
		.mosi(mosi)
	);

	assign busy = (state != seqIdle);
	assign push = (state == seqData) & byteDone; // header bytes never reach here
	assign pushData = rxByte;

	// next byte goes out the cycle after byteDone
	// data bytes also wait for room in the buffer, csN stays low meanwhile
	always_comb begin
		load = 1'b0;
		if (!byteActive && !csSetup) begin
			case (state)
				seqCommand, seqAddress: load = 1'b1;
				seqData: load = !full && (dataLeft != '0);
				default: load = 1'b0;
			endcase
		end
	end

	always_comb begin
		case (state)
			seqCommand: txByte = opRead;
			seqAddress: begin
				case (stepCnt)
					2'd0: txByte = addrReg[ADDR_BITS-1 -: BYTE_BITS]; // a[23:16]
					2'd1: txByte = addrReg[ADDR_BITS-BYTE_BITS-1 -: BYTE_BITS];
					default: txByte = addrReg[BYTE_BITS-1:0];
				endcase
			end
			default: txByte = '0; // dummy byte while reading
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= seqIdle;
			csN <= 1'b1;
			csSetup <= 1'b0;
			byteActive <= 1'b0;
			stepCnt <= '0;
			dataLeft <= '0;
			readDone <= 1'b0;
		end else begin
			csSetup <= 1'b0;
			readDone <= 1'b0;
			if (load)
				byteActive <= 1'b1;
			else if (byteDone)
				byteActive <= 1'b0;
			case (state)
				seqIdle: begin
					if (start && wordCount != '0) begin
						state <= seqCommand;
						csN <= 1'b0;
						csSetup <= 1'b1;
						dataLeft <= {wordCount, 1'b0}; // two bytes per word
					end
				end
				seqCommand: begin
					if (byteDone) begin
						state <= seqAddress;
						stepCnt <= '0;
					end
				end
				seqAddress: begin
					if (byteDone) begin
						if (stepCnt == 2'd2)
							state <= seqData;
						else
							stepCnt <= stepCnt + 1'b1;
					end
				end
				seqData: begin
					if (load)
						dataLeft <= dataLeft - 1'b1;
					if (byteDone && dataLeft == '0) begin // last byte back
						state <= seqRelease;
						csN <= 1'b1;
						stepCnt <= '0;
					end
				end
				seqRelease: begin
					stepCnt <= stepCnt + 1'b1;
					if (stepCnt == 2'd1) begin // two cycles after csN rose
						state <= seqIdle;
						readDone <= 1'b1;
					end
				end
				default: state <= seqIdle;
			endcase
		end
	end

	// request address is payload
	always_ff @(posedge clk) begin
		if (state == seqIdle && start)
			addrReg <= startAddr;
	end

endmodule

`default_nettype wire

// ==== hdl/spiByteEngine.sv ====
// spi mode 0 full duplex byte shifter, sck at half clk
`timescale 1ns/1ps
`default_nettype none

module spiByteEngine (
	input wire clk,
	input wire rstN,
	input wire load, // start one byte, only taken while idle
	input wire [spiPkg::BYTE_BITS-1:0] txByte,
	input wire miso,
	output logic byteDone, // one cycle, rxByte valid here
	output logic [spiPkg::BYTE_BITS-1:0] rxByte,
	output logic sck,
	output logic mosi
);
	import spiPkg::*;

	spiState_t state;
	logic [$clog2(SCK_CYCLES)-1:0] cnt; // half-period counter, bit 0 is sck
	logic [BYTE_BITS-1:0] shiftReg; // tx bits leave at msb, rx bits enter at lsb
	logic misoBit; // miso held from the rising edge until the falling edge

	assign sck = (state == spiShift) & cnt[0];
	assign mosi = (state == spiShift) & shiftReg[BYTE_BITS-1];
	assign byteDone = (state == spiFinish);
	assign rxByte = shiftReg; // all 8 bits in once we reach finish

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= spiIdle;
			cnt <= '0;
		end else begin
			case (state)
				spiIdle: begin
					if (load) begin
						state <= spiShift;
						cnt <= '0;
					end
				end
				spiShift: begin
					cnt <= cnt + 1'b1;
					// 16 half periods, then one cycle to report
					if (cnt == ($clog2(SCK_CYCLES))'(SCK_CYCLES - 1))
						state <= spiFinish;
				end
				default: state <= spiIdle; // finish is a single cycle
			endcase
		end
	end

	// duplex shifter
	// even count: sck goes high at this edge, so sample miso now
	// odd count: sck goes low, next mosi bit appears and sampled bit moves in
	always_ff @(posedge clk) begin
		if (state == spiIdle && load) begin
			shiftReg <= txByte; // msb is on mosi before the first rising edge
		end else if (state == spiShift) begin
			if (!cnt[0])
				misoBit <= miso;
			else
				shiftReg <= {shiftReg[BYTE_BITS-2:0], misoBit};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/spiPkg.sv ====
// serial link constants and byte engine state type
`default_nettype none

package spiPkg;

	localparam int BYTE_BITS = 8; // bits per spi byte, msb first
	localparam int SCK_CYCLES = 16; // clk cycles per byte, sck = clk/2

	// byte engine states
	// spiIdle waits for load, spiShift runs sck, spiFinish flags byteDone
	typedef enum logic [1:0] {
		spiIdle,
		spiShift,
		spiFinish
	} spiState_t;

endpackage

`default_nettype wire

// ==== hdl/wordReader.sv ====
// word assembler, pops two buffer bytes per host request, low byte first
`timescale 1ns/1ps
`default_nettype none

module wordReader (
	input wire clk,
	input wire rstN,
	input wire next, // one-cycle request, ignored while a word is pending
	input wire [spiPkg::BYTE_BITS-1:0] popData,
	input wire empty,
	output logic pop,
	output logic [2*spiPkg::BYTE_BITS-1:0] word, // held until the next wordValid
	output logic wordValid
);
	import spiPkg::*;

	logic pending; // request taken, word not yet out
	logic gotLow; // first byte already pulled
	logic [BYTE_BITS-1:0] lowByte;

	// pull whenever a request is open and there is data
	assign pop = pending & !empty;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pending <= 1'b0;
			gotLow <= 1'b0;
			wordValid <= 1'b0;
		end else begin
			wordValid <= 1'b0;
			if (!pending) begin
				if (next) begin
					pending <= 1'b1;
					gotLow <= 1'b0;
				end
			end else if (!empty) begin
				if (!gotLow) begin
					gotLow <= 1'b1;
				end else begin // high byte goes now, word complete
					pending <= 1'b0;
					gotLow <= 1'b0;
					wordValid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop && !gotLow)
			lowByte <= popData;
		if (pop && gotLow)
			word <= {popData, lowByte}; // first byte from flash in low half
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the flash reader testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module flashReaderTb -f compile.f
out=$(./obj_dir/VflashReaderTb)
echo "$out"
if echo "$out" | grep -q "=== PASS ==="; then
	exit 0
fi
exit 1

// ==== tests/flashModel.sv ====
// behavioral serial NOR flash, answers READ with address-derived data bytes
`timescale 1ns/1ps
`default_nettype none

module flashModel (
	input wire sck,
	input wire csN,
	input wire mosi,
	output logic miso
);
	logic [31:0] cmdShift; // opcode then 24-bit address
	int bitCnt; // sck rising edges since csN fell
	int dataIdx;
	logic [23:0] byteAddr;
	logic [7:0] dataByte; // byte being shifted out on miso

	// data byte rule of the model, address counter wraps at 24 bits
	function automatic logic [7:0] dataAt(input logic [23:0] a);
		return a[7:0] ^ a[15:8] ^ 8'hA5;
	endfunction

	initial begin
		miso = 1'b0;
		bitCnt = 0;
		cmdShift = '0;
	end

	always @(negedge csN) bitCnt = 0; // new command

	always @(posedge sck) begin
		if (!csN) begin
			if (bitCnt < 32)
				cmdShift = {cmdShift[30:0], mosi}; // header, msb first
			bitCnt = bitCnt + 1;
		end
	end

	// mode 0, next bit goes out on the falling edge
	always @(negedge sck) begin
		if (!csN && bitCnt >= 32) begin
			dataIdx = bitCnt - 32;
			byteAddr = cmdShift[23:0] + 24'(dataIdx / 8);
			dataByte = dataAt(byteAddr);
			miso = dataByte[7 - (dataIdx % 8)];
		end
	end

endmodule

`default_nettype wire

// ==== tests/flashReaderTb.sv ====
// testbench top: clock, reset, request table loop, watchdog and final report
`timescale 1ns/1ps
`default_nettype none

module flashReaderTb;
	localparam int N_ENTRIES = 5;

	logic clk = 1'b0;
	logic rstN;
	logic start;
	logic [23:0] startAddr;
	logic [7:0] wordCount;
	logic next;
	logic miso;
	logic sck;
	logic csN;
	logic mosi;
	logic busy;
	logic readDone;
	logic [15:0] word;
	logic wordValid;
	logic endOfTest;
	int errorCount;
	int seed = 32'h402f;
	longint limitNs;

	// request table: address, words, gap base and random spread in cycles
	logic [23:0] tblAddr [N_ENTRIES] = '{24'h000000, 24'h1234FE, 24'hABCDEF, 24'h00FFF8, 24'hFFFFFC};
	int tblCount [N_ENTRIES] = '{4, 6, 0, 12, 3}; // zero count must be ignored
	int tblGapBase [N_ENTRIES] = '{0, 2, 0, 60, 0}; // long gaps fill the buffer
	int tblGapSpread [N_ENTRIES] = '{4, 8, 0, 20, 3};

	always #2 clk = ~clk; // 4 ns

	flashReader i_dut (
		.clk(clk), .rstN(rstN), .start(start), .startAddr(startAddr),
		.wordCount(wordCount), .next(next), .miso(miso), .sck(sck), .csN(csN),
		.mosi(mosi), .busy(busy), .readDone(readDone), .word(word), .wordValid(wordValid)
	);

	flashModel i_flash (.sck(sck), .csN(csN), .mosi(mosi), .miso(miso));

	readChecker i_checker (
		.clk(clk), .rstN(rstN), .start(start), .startAddr(startAddr),
		.wordCount(wordCount), .busy(busy), .csN(csN), .sck(sck), .mosi(mosi),
		.readDone(readDone), .word(word), .wordValid(wordValid),
		.endOfTest(endOfTest), .errorCount(errorCount)
	);

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic pulseStart(input logic [23:0] addr, input logic [7:0] count);
		@(posedge clk);
		#1 start = 1'b1;
		startAddr = addr;
		wordCount = count;
		@(posedge clk);
		#1 start = 1'b0;
	endtask

	// one next strobe, then wait for the word
	task automatic requestWord();
		@(posedge clk);
		#1 next = 1'b1;
		@(posedge clk);
		#1 next = 1'b0;
		do @(posedge clk); while (!wordValid);
	endtask

	// watchdog, budget from the table
	initial begin
		limitNs = 0;
		for (int e = 0; e < N_ENTRIES; e++)
			limitNs += (5 + 2 * tblCount[e]) * 17 * 4
				+ tblCount[e] * (tblGapBase[e] + tblGapSpread[e]) * 4;
		limitNs = 2 * limitNs;
		#(limitNs);
		$display("run timed out after %0d ns, DUT stopped responding", limitNs);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		start = 1'b0;
		startAddr = '0;
		wordCount = '0;
		next = 1'b0;
		endOfTest = 1'b0;
		waitCycles(3);
		#1 rstN = 1'b1;
		waitCycles(4); // idle outputs checked here
		for (int e = 0; e < N_ENTRIES; e++) begin
			pulseStart(tblAddr[e], 8'(tblCount[e]));
			if (tblCount[e] == 0) begin
				waitCycles(20); // nothing should start
			end else begin
				for (int w = 0; w < tblCount[e]; w++) begin
					waitCycles(tblGapBase[e] + int'($unsigned($random(seed))
						% (tblGapSpread[e] + 1)));
					requestWord();
					if (w == 0 && tblCount[e] >= 3)
						pulseStart(24'h777777, 8'd2); // busy, must be dropped
				end
				while (busy) @(posedge clk);
			end
			waitCycles(8);
		end
		@(posedge clk);
		#1 endOfTest = 1'b1;
		@(posedge clk);
		#1 endOfTest = 1'b0;
		waitCycles(2);
		$display("checks done, %0d errors", errorCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/flashReader_assert.sv ====
// concurrent checks on buffer push/pop and chip select stability
`timescale 1ns/1ps
`default_nettype none

module flashReaderAssert (
	input wire clk,
	input wire rstN,
	input wire push,
	input wire pop,
	input wire full,
	input wire empty,
	input wire csN,
	input wire midByte // engine busy and not finishing
);
	pushNotFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
		else $error("push while buffer full");
	popNotEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
		else $error("pop while buffer empty");
	csStable: assert property (@(posedge clk) disable iff (!rstN) midByte |=> $stable(csN))
		else $error("csN moved in the middle of a byte");
endmodule

bind byteFifo flashReaderAssert i_fifoAssert (
	.clk(clk), .rstN(rstN), .push(push), .pop(pop), .full(full), .empty(empty),
	.csN(1'b1), .midByte(1'b0)
);

bind readSequencer flashReaderAssert i_seqAssert (
	.clk(clk), .rstN(rstN), .push(push), .pop(1'b0), .full(full), .empty(1'b0),
	.csN(csN), .midByte(byteActive & !byteDone)
);

`default_nettype wire

// ==== tests/readChecker.sv ====
// DUT port monitor, decodes the spi header and compares returned words
`timescale 1ns/1ps
`default_nettype none

module readChecker (
	input wire clk,
	input wire rstN,
	input wire start,
	input wire [flashPkg::ADDR_BITS-1:0] startAddr,
	input wire [flashPkg::WORD_COUNT_BITS-1:0] wordCount,
	input wire busy,
	input wire csN,
	input wire sck,
	input wire mosi,
	input wire readDone,
	input wire [15:0] word,
	input wire wordValid,
	input wire endOfTest, // final bookkeeping checks
	output int errorCount
);
	logic csPrev;
	logic sckPrev;
	logic anyStart; // nothing requested yet since reset
	logic reqPending; // accepted start, csN not yet fallen
	logic reqSeen;
	logic stallSeen;
	logic [23:0] reqAddr;
	logic [23:0] curAddr; // flash address of the next expected word
	int reqCount;
	int wordsSeen;
	int doneSeen;
	int hdrBits;
	int idleSck; // cycles without an sck edge while csN low
	logic [31:0] hdrShift;

	function automatic logic [7:0] expByte(input logic [23:0] a);
		return a[7:0] ^ a[15:8] ^ 8'hA5;
	endfunction

	task automatic reportError(input string msg);
		errorCount++;
		$display("** Error @ %0t: %s", $time, msg);
	endtask

	// totals of the previous request
	task automatic closeRequest();
		if (reqSeen && wordsSeen != reqCount)
			reportError($sformatf("got %0d words, expected %0d", wordsSeen, reqCount));
		if (reqSeen && doneSeen != 1)
			reportError($sformatf("readDone pulsed %0d times, expected once", doneSeen));
	endtask

	initial begin
		errorCount = 0;
		csPrev = 1'b1;
		sckPrev = 1'b0;
		anyStart = 1'b0;
		reqPending = 1'b0;
		reqSeen = 1'b0;
		stallSeen = 1'b0;
		idleSck = 0;
		hdrBits = 32;
	end

	always @(posedge clk) begin
		if (rstN) begin
			if (!anyStart && (!csN || sck || busy || wordValid))
				reportError("outputs not idle after reset");
			if (csPrev && !csN) begin // csN fall
				if (!reqPending)
					reportError("csN fell without an accepted start");
				reqPending = 1'b0;
				hdrBits = 0;
			end
			if (!csN && sck && !sckPrev && hdrBits < 32) begin // header bit
				hdrShift = {hdrShift[30:0], mosi};
				hdrBits++;
				if (hdrBits == 32 && hdrShift != {8'h03, reqAddr})
					reportError($sformatf("header %h, expected %h", hdrShift, {8'h03, reqAddr}));
			end
			if (!csN && sck == sckPrev)
				idleSck++;
			else
				idleSck = 0;
			if (idleSck >= 20)
				stallSeen = 1'b1; // buffer full held sck
			if (wordValid) begin
				if (word !== {expByte(curAddr + 24'd1), expByte(curAddr)})
					reportError($sformatf("word %h at %h, expected %h", word, curAddr,
						{expByte(curAddr + 24'd1), expByte(curAddr)}));
				curAddr = curAddr + 24'd2;
				wordsSeen++;
			end
			if (readDone) begin
				doneSeen++;
				if (!csN)
					reportError("readDone while csN low");
			end
			if (start) begin
				anyStart = 1'b1;
				if (!busy && wordCount != '0) begin // accepted
					closeRequest();
					reqSeen = 1'b1;
					reqPending = 1'b1;
					reqAddr = startAddr;
					curAddr = startAddr;
					reqCount = int'(wordCount);
					wordsSeen = 0;
					doneSeen = 0;
				end
			end
			if (endOfTest) begin
				closeRequest();
				reqSeen = 1'b0;
				if (!stallSeen)
					reportError("sck never stalled on a full buffer");
			end
		end
		csPrev = csN;
		sckPrev = sck;
	end

endmodule

`default_nettype wire
